// File: rtl/cache_pkg.sv
//##########################################################
// data cache widths and port types
//##########################################################
package cache_pkg;

    localparam int addr_bits   = 27;
    localparam int word_bits   = 32;
    localparam int line_words  = 4;
    localparam int line_bits   = word_bits * line_words;
    localparam int offset_bits = 4;
    localparam int word_sel_lo = 2;   // bits [1:0] pick a byte
    localparam int num_ways    = 2;

    typedef logic [addr_bits-1:0]             addr_t;
    typedef logic [word_bits-1:0]             word_t;
    typedef logic [line_bits-1:0]             line_t;
    typedef logic [addr_bits-offset_bits-1:0] line_addr_t;  // also the tag
    typedef logic [$clog2(num_ways)-1:0]      way_t;

    // pipeline memory stage to cache
    typedef struct packed {
        logic  rd_en;
        logic  wr_en;
        addr_t addr;
        word_t wdata;
    } core_req_t;

    typedef struct packed {
        logic  rd_fin;
        logic  wr_fin;
        word_t rdata;
    } core_rsp_t;

    // cache to DDR controller
    typedef struct packed {
        logic  rd_en;
        addr_t rd_addr;
        logic  wr_en;
        addr_t wr_addr;
        line_t wr_line;
    } mem_req_t;

    typedef struct packed {
        logic  rd_fin;
        logic  wr_fin;
        line_t rd_line;
    } mem_rsp_t;

endpackage

// File: rtl/sync_ram.sv
//##########################################################
// single-port RAM, registered read
//##########################################################
`timescale 1ns/1ps

module sync_ram #(
    parameter int  index_bits = 6,
    parameter type entry_t    = logic
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [index_bits-1:0] index,
    input  entry_t                wdata,
    output entry_t                rdata
);

    localparam int depth = 2 ** index_bits;

    entry_t mem [depth];

    // read returns the old entry when written in the same cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
        rdata <= mem[index];
    end

endmodule

// File: rtl/way_policy.sv
//##########################################################
// valid bits, replacement and tag match
//##########################################################
`timescale 1ns/1ps

module way_policy #(
    parameter int index_bits = 6
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [index_bits-1:0] index,
    input  cache_pkg::line_addr_t req_line,
    input  cache_pkg::line_addr_t way0_tag,
    input  cache_pkg::line_addr_t way1_tag,
    input  logic                  update,
    input  cache_pkg::way_t       update_way,
    output logic                  hit,
    output cache_pkg::way_t       hit_way,
    output cache_pkg::way_t       victim
);
    import cache_pkg::*;

    localparam int num_sets = 2 ** index_bits;

    logic [num_ways-1:0]   valid_q [num_sets];
    logic [num_sets-1:0]   repl_q;       // way to evict next
    logic [index_bits-1:0] look_idx;     // lines up with tag RAM output
    logic [num_ways-1:0]   set_valid;
    logic                  hit0;
    logic                  hit1;

    always_ff @(posedge clk) begin
        look_idx <= index;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
            end
            repl_q <= '0;
        end else if (update) begin
            valid_q[index][update_way] <= 1'b1;
            repl_q[index] <= ~update_way;   // point at the other way
        end
    end

    assign set_valid = valid_q[look_idx];
    assign hit0      = set_valid[0] && (way0_tag == req_line);
    assign hit1      = set_valid[1] && (way1_tag == req_line);
    assign hit       = hit0 | hit1;
    assign hit_way   = way_t'(hit1);

    // empty way first, else the replacement bit
    always_comb begin
        if (!set_valid[0]) begin
            victim = way_t'(0);
        end else if (!set_valid[1]) begin
            victim = way_t'(1);
        end else begin
            victim = repl_q[look_idx];
        end
    end

endmodule

// File: rtl/word_lane.sv
//##########################################################
// word select and merge
//##########################################################
`timescale 1ns/1ps

module word_lane (
    input  cache_pkg::line_t                                         line_in,
    input  logic [cache_pkg::offset_bits-cache_pkg::word_sel_lo-1:0] word_sel,
    input  cache_pkg::word_t                                         wdata,
    output cache_pkg::word_t                                         rword,
    output cache_pkg::line_t                                         merged
);
    import cache_pkg::*;

    assign rword = line_in[word_sel*word_bits +: word_bits];

    // only the addressed word is replaced
    always_comb begin
        for (int i = 0; i < line_words; i++) begin
            if (word_sel == i) begin
                merged[i*word_bits +: word_bits] = wdata;
            end else begin
                merged[i*word_bits +: word_bits] = line_in[i*word_bits +: word_bits];
            end
        end
    end

endmodule

// File: rtl/cache_ctrl.sv
//##########################################################
// cache controller FSM
//##########################################################
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int index_bits = 6
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  cache_pkg::core_req_t            core_req,
    output cache_pkg::core_rsp_t            core_rsp,
    output cache_pkg::mem_req_t             mem_req,
    input  cache_pkg::mem_rsp_t             mem_rsp,
    output logic [index_bits-1:0]           ram_index,
    output logic [cache_pkg::num_ways-1:0]  tag_we,
    output logic [cache_pkg::num_ways-1:0]  data_we,
    output cache_pkg::line_addr_t           fill_tag,
    output cache_pkg::line_t                fill_line,
    input  cache_pkg::line_t                rd_line0,
    input  cache_pkg::line_t                rd_line1,
    input  logic                            hit,
    input  cache_pkg::way_t                 hit_way,
    input  cache_pkg::way_t                 victim,
    output logic                            update,
    output cache_pkg::way_t                 update_way
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_rd_miss,     // waiting for the line from DDR
        st_wr_through,  // waiting for DDR write done
        st_wr_fetch     // write-allocate fetch
    } state_t;

    state_t    state;
    core_req_t req_q;
    way_t      victim_q;
    logic      start;
    addr_t     line_base;
    line_t     lane_line;
    word_t     lane_word;
    line_t     lane_merged;

    assign start = (state == st_idle) && (core_req.rd_en || core_req.wr_en);

    // new request goes straight to the RAMs so data is there in compare
    assign ram_index = start ? core_req.addr[offset_bits +: index_bits]
                             : req_q.addr[offset_bits +: index_bits];

    assign fill_tag  = req_q.addr[addr_bits-1:offset_bits];
    assign line_base = {fill_tag, {offset_bits{1'b0}}};

    // cached line while comparing, DDR line otherwise
    assign lane_line = (state == st_compare) ? (hit_way ? rd_line1 : rd_line0)
                                             : mem_rsp.rd_line;

    word_lane lane_inst (
        .line_in  (lane_line),
        .word_sel (req_q.addr[offset_bits-1:word_sel_lo]),
        .wdata    (req_q.wdata),
        .rword    (lane_word),
        .merged   (lane_merged)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state           <= st_idle;
            core_rsp.rd_fin <= 1'b0;
            core_rsp.wr_fin <= 1'b0;
            mem_req.rd_en   <= 1'b0;
            mem_req.wr_en   <= 1'b0;
            tag_we          <= '0;
            data_we         <= '0;
            update          <= 1'b0;
        end else begin
            // pulses last one cycle
            core_rsp.rd_fin <= 1'b0;
            core_rsp.wr_fin <= 1'b0;
            mem_req.rd_en   <= 1'b0;
            mem_req.wr_en   <= 1'b0;
            tag_we          <= '0;
            data_we         <= '0;
            update          <= 1'b0;

            case (state)
                st_idle: begin
                    if (start) begin
                        req_q <= core_req;
                        state <= st_compare;
                    end
                end

                st_compare: begin
                    victim_q <= victim;
                    if (hit && req_q.rd_en) begin
                        core_rsp.rd_fin <= 1'b1;
                        core_rsp.rdata  <= lane_word;
                        update          <= 1'b1;
                        update_way      <= hit_way;
                        state           <= st_idle;
                    end else if (hit) begin
                        data_we[hit_way] <= 1'b1;   // tag is unchanged
                        fill_line        <= lane_merged;
                        mem_req.wr_en    <= 1'b1;
                        mem_req.wr_addr  <= line_base;
                        mem_req.wr_line  <= lane_merged;
                        update           <= 1'b1;
                        update_way       <= hit_way;
                        state            <= st_wr_through;
                    end else begin
                        mem_req.rd_en   <= 1'b1;
                        mem_req.rd_addr <= line_base;
                        state           <= req_q.wr_en ? st_wr_fetch : st_rd_miss;
                    end
                end

                st_rd_miss: begin
                    if (mem_rsp.rd_fin) begin
                        tag_we[victim_q]  <= 1'b1;
                        data_we[victim_q] <= 1'b1;
                        fill_line         <= mem_rsp.rd_line;
                        update            <= 1'b1;
                        update_way        <= victim_q;
                        core_rsp.rd_fin   <= 1'b1;
                        core_rsp.rdata    <= lane_word;
                        state             <= st_idle;
                    end
                end

                st_wr_fetch: begin
                    if (mem_rsp.rd_fin) begin
                        tag_we[victim_q]  <= 1'b1;
                        data_we[victim_q] <= 1'b1;
                        fill_line         <= lane_merged;
                        mem_req.wr_en     <= 1'b1;
                        mem_req.wr_addr   <= line_base;
                        mem_req.wr_line   <= lane_merged;
                        update            <= 1'b1;
                        update_way        <= victim_q;
                        state             <= st_wr_through;
                    end
                end

                st_wr_through: begin
                    if (mem_rsp.wr_fin) begin
                        core_rsp.wr_fin <= 1'b1;
                        state           <= st_idle;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: rtl/cache_top.sv
//##########################################################
// two-way data cache top
//##########################################################
`timescale 1ns/1ps

module cache_top #(
    parameter int index_bits = 6
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  cache_pkg::core_req_t core_req,
    output cache_pkg::core_rsp_t core_rsp,
    output cache_pkg::mem_req_t  mem_req,
    input  cache_pkg::mem_rsp_t  mem_rsp
);
    import cache_pkg::*;

    logic [index_bits-1:0] ram_index;
    logic [num_ways-1:0]   tag_we;
    logic [num_ways-1:0]   data_we;
    line_addr_t            fill_tag;
    line_t                 fill_line;
    line_addr_t            tag0;
    line_addr_t            tag1;
    line_t                 line0;
    line_t                 line1;
    logic                  hit;
    way_t                  hit_way;
    way_t                  victim;
    logic                  update;
    way_t                  update_way;

    cache_ctrl #(.index_bits(index_bits)) ctrl_inst (
        .clk        (clk),
        .rstn       (rstn),
        .core_req   (core_req),
        .core_rsp   (core_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .ram_index  (ram_index),
        .tag_we     (tag_we),
        .data_we    (data_we),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .rd_line0   (line0),
        .rd_line1   (line1),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim     (victim),
        .update     (update),
        .update_way (update_way)
    );

    way_policy #(.index_bits(index_bits)) policy_inst (
        .clk        (clk),
        .rstn       (rstn),
        .index      (ram_index),
        .req_line   (fill_tag),
        .way0_tag   (tag0),
        .way1_tag   (tag1),
        .update     (update),
        .update_way (update_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim     (victim)
    );

    // tag RAMs hold the full line address
    sync_ram #(.index_bits(index_bits), .entry_t(line_addr_t)) tag_ram0 (
        .clk(clk), .we(tag_we[0]), .index(ram_index), .wdata(fill_tag), .rdata(tag0)
    );
    sync_ram #(.index_bits(index_bits), .entry_t(line_addr_t)) tag_ram1 (
        .clk(clk), .we(tag_we[1]), .index(ram_index), .wdata(fill_tag), .rdata(tag1)
    );

    sync_ram #(.index_bits(index_bits), .entry_t(line_t)) data_ram0 (
        .clk(clk), .we(data_we[0]), .index(ram_index), .wdata(fill_line), .rdata(line0)
    );
    sync_ram #(.index_bits(index_bits), .entry_t(line_t)) data_ram1 (
        .clk(clk), .we(data_we[1]), .index(ram_index), .wdata(fill_line), .rdata(line1)
    );

endmodule

// File: verif/ddr_model.sv
//##########################################################
// behavioral DDR model
//##########################################################
`timescale 1ns/1ps

module ddr_model (
    input  logic                clk,
    input  logic                rstn,
    input  cache_pkg::mem_req_t mem_req,
    output cache_pkg::mem_rsp_t mem_rsp,
    output logic                log_wr,     // one pulse per completed write
    output cache_pkg::addr_t    log_addr,
    output cache_pkg::line_t    log_line
);
    import cache_pkg::*;

    line_t       lines [256];   // low 8 line-address bits
    logic [31:0] lfsr_q;
    logic        busy;
    logic        is_wr;
    logic [3:0]  wait_cnt;
    addr_t       op_addr;
    line_t       op_line;

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    initial begin
        lfsr_q = 32'h5b0;
        for (int l = 0; l < 256; l++) begin
            for (int i = 0; i < line_words; i++) begin
                lines[l][i*word_bits +: word_bits] = l * 4 + i;
            end
        end
    end

    always @(posedge clk) begin
        mem_rsp.rd_fin <= 1'b0;
        mem_rsp.wr_fin <= 1'b0;
        log_wr         <= 1'b0;
        if (!rstn) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 4'd1) begin
                busy <= 1'b0;
                if (is_wr) begin
                    lines[op_addr[offset_bits +: 8]] <= op_line;
                    mem_rsp.wr_fin <= 1'b1;
                    log_wr         <= 1'b1;
                    log_addr       <= op_addr;
                    log_line       <= op_line;
                end else begin
                    mem_rsp.rd_fin  <= 1'b1;
                    mem_rsp.rd_line <= lines[op_addr[offset_bits +: 8]];
                end
            end else begin
                wait_cnt <= wait_cnt - 4'd1;
            end
        end else if (mem_req.rd_en || mem_req.wr_en) begin
            busy     <= 1'b1;
            is_wr    <= mem_req.wr_en;
            op_addr  <= mem_req.wr_en ? mem_req.wr_addr : mem_req.rd_addr;
            op_line  <= mem_req.wr_line;
            wait_cnt <= 4'(take_bits(3)) + 4'd1;   // 1 to 8 cycles
        end
    end

endmodule

// File: verif/cache_tb.sv
//##########################################################
// data cache testbench
//##########################################################
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int num_random = 60;
    localparam int num_reqs   = 12 + num_random;
    localparam int max_cycles = num_reqs * 40;

    logic      clk;
    logic      rstn;
    core_req_t core_req;
    core_rsp_t core_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;
    logic      log_wr;
    addr_t     log_addr;
    line_t     log_line;

    word_t       ref_mem [1024];   // indexed by address bits [11:2]
    logic [31:0] lfsr_q;
    int          errors, cycles, issued, ddr_rd, ddr_wr, rd_fins, wr_fins;
    int          pending;          // 0 none, 1 read, 2 write
    logic        started;
    word_t       exp_rdata;
    addr_t       exp_addr;
    addr_t       exp_base;

    cache_top #(.index_bits(6)) cache_top_inst (
        .clk(clk), .rstn(rstn), .core_req(core_req), .core_rsp(core_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    ddr_model ddr_inst (
        .clk(clk), .rstn(rstn), .mem_req(mem_req), .mem_rsp(mem_rsp),
        .log_wr(log_wr), .log_addr(log_addr), .log_line(log_line)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic line_t expected_line(input addr_t addr);
        line_t l;
        for (int i = 0; i < line_words; i++) begin
            l[i*word_bits +: word_bits] = ref_mem[{addr[11:4], 2'(i)}];
        end
        return l;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles, a request never finished", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!started) begin
            assert (!core_rsp.rd_fin && !core_rsp.wr_fin && !mem_req.rd_en && !mem_req.wr_en)
            else begin
                $display("FAIL early pulse rd_fin=%h wr_fin=%h mem rd_en=%h wr_en=%h",
                         core_rsp.rd_fin, core_rsp.wr_fin, mem_req.rd_en, mem_req.wr_en);
                errors++;
            end
        end
        if (mem_req.rd_en) begin
            ddr_rd++;
            assert (mem_req.rd_addr == exp_base) else begin
                $display("FAIL mem_req.rd_addr=%h expected %h", mem_req.rd_addr, exp_base);
                errors++;
            end
        end
        if (log_wr) begin
            ddr_wr++;
            assert (log_addr == exp_base) else begin
                $display("FAIL log_addr=%h expected %h", log_addr, exp_base);
                errors++;
            end
            assert (log_line == expected_line(exp_addr)) else begin
                $display("FAIL log_line=%h expected %h", log_line, expected_line(exp_addr));
                errors++;
            end
        end
        if (core_rsp.rd_fin) begin
            rd_fins++;
            assert (pending == 1) else begin
                $display("read finish arrived with no read outstanding");
                errors++;
            end
            assert (core_rsp.rdata == exp_rdata) else begin
                $display("FAIL rdata=%h expected %h", core_rsp.rdata, exp_rdata);
                errors++;
            end
            pending = 0;
        end
        if (core_rsp.wr_fin) begin
            wr_fins++;
            assert (pending == 2) else begin
                $display("write finish arrived with no write outstanding");
                errors++;
            end
            pending = 0;
        end
    end

    task automatic access(input logic is_wr, input addr_t addr, input word_t data,
                          output int lat);
        exp_addr  = addr;
        exp_base  = {addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
        exp_rdata = ref_mem[addr[11:2]];
        if (is_wr) ref_mem[addr[11:2]] = data;
        pending = is_wr ? 2 : 1;
        started = 1'b1;
        issued++;
        core_req.rd_en = !is_wr;
        core_req.wr_en = is_wr;
        core_req.addr  = addr;
        core_req.wdata = data;
        @(posedge clk);
        #1;
        core_req.rd_en = 1'b0;
        core_req.wr_en = 1'b0;
        lat = 0;
        while (pending != 0) begin
            @(posedge clk);
            lat++;
        end
        #1;
    endtask

    // want_lat of 0 skips the latency check
    task automatic step(input logic is_wr, input addr_t addr, input word_t data,
                        input int want_rd, input int want_lat);
        int rd0, wr0, lat;
        rd0 = ddr_rd;
        wr0 = ddr_wr;
        access(is_wr, addr, data, lat);
        assert (ddr_rd - rd0 == want_rd) else begin
            $display("FAIL ddr rd_en count=%h expected %h", ddr_rd - rd0, want_rd);
            errors++;
        end
        assert (ddr_wr - wr0 == int'(is_wr)) else begin
            $display("FAIL ddr wr_en count=%h expected %h", ddr_wr - wr0, int'(is_wr));
            errors++;
        end
        if (want_lat > 0) begin
            assert (lat == want_lat) else begin
                $display("FAIL rd_fin latency=%h expected %h", lat, want_lat);
                errors++;
            end
        end
    endtask

    initial begin
        int    lat;
        addr_t addr;
        logic  is_wr;
        word_t data;
        clk = 1'b0;
        rstn = 1'b0;
        core_req = '0;
        lfsr_q = 32'h5b0;
        started = 1'b0;
        pending = 0;
        {errors, cycles, issued, ddr_rd, ddr_wr, rd_fins, wr_fins} = '0;
        for (int w = 0; w < 1024; w++) ref_mem[w] = w;   // same fill as DDR
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        repeat (3) @(posedge clk);
        #1;

        step(0, 27'h054, '0, 1, 0);               // cold read
        step(0, 27'h058, '0, 0, 2);               // same line hits
        step(1, 27'h05c, 32'hcafe_0001, 0, 0);    // write-through hit
        step(0, 27'h05c, '0, 0, 2);
        step(1, 27'h094, 32'h1234_5678, 1, 0);    // write-allocate
        step(0, 27'h094, '0, 0, 2);

        // set 3 holds lines 3, 67 and 131
        step(0, 27'h030, '0, 1, 0);
        step(0, 27'h430, '0, 1, 0);
        step(0, 27'h030, '0, 0, 2);
        step(0, 27'h830, '0, 1, 0);               // evicts 67
        step(0, 27'h034, '0, 0, 2);
        step(0, 27'h438, '0, 1, 0);

        // four sets, four tags each
        for (int n = 0; n < num_random; n++) begin
            addr = '0;
            addr[2 +: 2]  = 2'(take_bits(2));
            addr[4 +: 2]  = 2'(take_bits(2));
            addr[10 +: 2] = 2'(take_bits(2));
            is_wr = 1'(take_bits(1));
            data  = take_bits(32);
            access(is_wr, addr, data, lat);
        end

        assert (rd_fins + wr_fins == issued) else begin
            $display("FAIL fin count=%h expected %h", rd_fins + wr_fins, issued);
            errors++;
        end
        $display("requests %0d, read fins %0d, write fins %0d, errors %0d",
                 issued, rd_fins, wr_fins, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/cache_pkg.sv
rtl/sync_ram.sv
rtl/way_policy.sv
rtl/word_lane.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
verif/ddr_model.sv
verif/cache_tb.sv
